/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_mcu_power
FILELIST := list.f
OBJDIR   := obj_dir
PASS_MSG := Verification passed

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* list.f */
+incdir+src
src/pwr_pkg.sv
src/pwr_seq_ctrl.sv
src/pwr_domain_regs.sv
src/ack_wait.sv
src/irq_wakeup.sv
src/mcu_power_top.sv
sim/tb_clk_gen.sv
sim/tb_mcu_power.sv

/* sim/power_stimulus.txt */
# name kind(cmd/drop/irq) dom op(0 off 1 retain 2 on) src mask delay exp_word exp_err exp_irq
# src, mask, exp_word and exp_irq in hex; delay in cycles, 255 means the switch never answers
irq_timers         irq  0 0 e000 ffff   0 1f 0 0007
irq_spi_dma        irq  0 0 1c00 ffff   0 1f 0 0038
irq_gpio           irq  0 0 03fc ffff   0 1f 0 3fc0
irq_win_ext        irq  0 0 0007 ffff   0 1f 0 c040
irq_mask_part      irq  0 0 ffff 0f0f   0 1f 0 0f0f
irq_timer2_only    irq  0 0 4000 0002   0 1f 0 0002
off_bank2          cmd  2 0 0000 0000   3 01 0 0000
on_bank2           cmd  2 2 0000 0000   5 1f 0 0000
retain_bank3       cmd  3 1 0000 0000   0 10 0 0000
on_bank3           cmd  3 2 0000 0000   2 1f 0 0000
ack_timeout_bank4  cmd  4 0 0000 0000 255 01 1 0000
on_bank4           cmd  4 2 0000 0000   3 1f 0 0000
drop_while_busy    drop 5 0 0000 0000   4 01 0 0000
on_bank5           cmd  5 2 0000 0000   1 1f 0 0000
retain_periph      cmd  1 1 0000 0000   0 11 0 0000
on_periph          cmd  1 2 0000 0000   2 1f 0 0000
off_cpu            cmd  0 0 0000 0000   2 01 0 0000
wake_masked        irq  0 0 0800 0000   0 01 0 0000
wake_unmasked      irq  0 0 0800 0010   0 1f 0 0010

/* sim/tb_clk_gen.sv */
/*
 * testbench clock and synchronous reset
 */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* sim/tb_mcu_power.sv */
/*
 * testbench for the power controller top
 * stimulus file reader, switch acknowledge model, sequence checks
 */
`include "pwr_params.svh"

module tb_mcu_power
  import pwr_pkg::*;
();

  typedef struct packed {
    domain_id_t dom;
    pwr_op_e    op;
    irq_src_t   src;
    fast_irq_t  mask;
    logic [7:0] delay;
    pwr_ctrl_t  exp_word;
    logic       exp_err;
    fast_irq_t  exp_irq;
  } stim_t;

  logic                             clk;
  logic                             rst_n;
  logic                             cmd_valid;
  pwr_cmd_t                         cmd;
  irq_src_t                         irq_src;
  fast_irq_t                        irq_mask;
  logic [`PWR_NUM_DOMAINS-1:0]      switch_ack_n;
  pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] pwr_ctrl;
  fast_irq_t                        fast_irq;
  logic                             busy;
  logic                             done;
  logic                             ack_err;

  stim_t stim_q[$];
  string name_q[$];
  string kind_q[$];
  int    ack_cnt [`PWR_NUM_DOMAINS];
  int    ack_delay;
  int    cycles = 0;
  int    cycle_limit = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mcu_power_top DUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .irq_src_i     (irq_src),
    .irq_mask_i    (irq_mask),
    .switch_ack_ni (switch_ack_n),
    .pwr_ctrl_o    (pwr_ctrl),
    .fast_irq_o    (fast_irq),
    .busy_o        (busy),
    .done_o        (done),
    .ack_err_o     (ack_err)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_equal(string what, int exp, int act);
    assert (exp == act) else begin
      $display("[FAIL] %s: expected %0h, actual %0h", what, exp, act);
      $display("Verification failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    string name;
    string kind;
    int    dom, op, delay, exp_err;
    int    src, mask, exp_word, exp_irq;
    stim_t s;
    fd = $fopen("sim/power_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/power_stimulus.txt");
      $display("Verification failed");
      $fatal(1, "no stimulus");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %s %d %d %h %h %d %h %d %h", name, kind, dom, op,
                  src, mask, delay, exp_word, exp_err, exp_irq);
      if (n != 10) begin
        $display("stimulus line could not be parsed: %s", line);
        $display("Verification failed");
        $fatal(1, "bad stimulus");
      end
      s.dom      = domain_id_t'(dom);
      s.op       = pwr_op_e'(op);
      s.src      = irq_src_t'(src);
      s.mask     = fast_irq_t'(mask);
      s.delay    = 8'(delay);
      s.exp_word = pwr_ctrl_t'(exp_word);
      s.exp_err  = 1'(exp_err);
      s.exp_irq  = fast_irq_t'(exp_irq);
      stim_q.push_back(s);
      name_q.push_back(name);
      kind_q.push_back(kind);
    end
    $fclose(fd);
  endtask

  // advance one cycle and run the switch model
  // ack follows the switch line after the delay
  task automatic tick();
    logic want;
    @(negedge clk);
    cmd_valid = 1'b0;
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      want = !pwr_ctrl[d].pwrgate_en_n;
      if (switch_ack_n[d] == want) begin
        ack_cnt[d] = 0;
      end else if (ack_delay != 255) begin
        if (ack_cnt[d] >= ack_delay) begin
          switch_ack_n[d] = want;
        end else begin
          ack_cnt[d]++;
        end
      end
    end
  endtask

  task automatic wait_busy(input logic decoy);
    while (!busy) begin
      tick();
    end
    // extra command to the peripheral domain that must be dropped
    if (decoy) begin
      cmd_valid = 1'b1;
      cmd       = '{dom: 3'd1, op: OP_OFF};
    end
  endtask

  task automatic check_power_down(string name, int dom, pwr_op_e op, logic decoy);
    pwr_ctrl_t exp;
    exp = pwr_ctrl[dom];
    wait_busy(decoy);
    tick();
    exp.clkgate_en_n = 1'b0;
    check_equal({name, " clock gated first"}, int'(exp), int'(pwr_ctrl[dom]));
    tick();
    exp.isogate_en_n = 1'b0;
    check_equal({name, " isolated second"}, int'(exp), int'(pwr_ctrl[dom]));
    tick();
    exp.rst_n = 1'b0;
    check_equal({name, " reset third"}, int'(exp), int'(pwr_ctrl[dom]));
    tick();
    if (op == OP_OFF) begin
      exp.pwrgate_en_n = 1'b0;
    end else if (dom >= 2) begin
      exp.retentive_en_n = 1'b0;
    end
    check_equal({name, " last step"}, int'(exp), int'(pwr_ctrl[dom]));
    if (op == OP_RETAIN) begin
      check_equal({name, " done without ack wait"}, 1, int'(done));
    end
  endtask

  task automatic check_power_up(string name, int dom, logic decoy);
    pwr_ctrl_t exp;
    exp = pwr_ctrl[dom];
    wait_busy(decoy);
    tick();
    exp.retentive_en_n = 1'b1;
    exp.pwrgate_en_n   = 1'b1;
    check_equal({name, " switch on"}, int'(exp), int'(pwr_ctrl[dom]));
    while (!pwr_ctrl[dom].isogate_en_n && !done) begin
      check_equal({name, " holding for ack"}, int'(exp), int'(pwr_ctrl[dom]));
      tick();
    end
    check_equal({name, " ack low at isolation release"}, 0, int'(switch_ack_n[dom]));
    exp.isogate_en_n = 1'b1;
    check_equal({name, " isolation released"}, int'(exp), int'(pwr_ctrl[dom]));
    tick();
    exp.rst_n = 1'b1;
    check_equal({name, " reset released"}, int'(exp), int'(pwr_ctrl[dom]));
    tick();
    exp.clkgate_en_n = 1'b1;
    check_equal({name, " clock ungated last"}, int'(exp), int'(pwr_ctrl[dom]));
  endtask

  task automatic check_done(string name, int dom, stim_t s, logic ack_needed,
                            pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] snap);
    while (!done) begin
      tick();
    end
    // power-off completes only once the switch has answered
    if (ack_needed) begin
      check_equal({name, " switch acknowledged before done"}, 1, int'(switch_ack_n[dom]));
    end
    check_equal({name, " busy at done"}, 0, int'(busy));
    check_equal({name, " ack_err"}, int'(s.exp_err), int'(ack_err));
    check_equal({name, " final word"}, int'(s.exp_word), int'(pwr_ctrl[dom]));
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      if (d != dom) begin
        check_equal({name, " other domain"}, int'(snap[d]), int'(pwr_ctrl[d]));
      end
    end
    tick();
    check_equal({name, " done one cycle"}, 0, int'(done));
  endtask

  initial begin
    stim_t                            s;
    pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] snap;
    pwr_ctrl_t                        cpu_exp;
    logic                             wake;
    cmd_valid    = 1'b0;
    cmd          = '0;
    irq_src      = '0;
    irq_mask     = '0;
    switch_ack_n = '0;
    ack_delay    = 0;
    cpu_exp      = '1;
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      ack_cnt[d] = 0;
    end
    read_stimulus();
    cycle_limit = stim_q.size() * (`PWR_ACK_TIMEOUT + 20) + 100;
    wait (rst_n === 1'b1);

    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      check_equal("reset control word", 'h1f, int'(pwr_ctrl[d]));
    end
    check_equal("reset busy", 0, int'(busy));
    check_equal("reset done", 0, int'(done));
    check_equal("reset ack_err", 0, int'(ack_err));

    foreach (stim_q[i]) begin
      s = stim_q[i];
      tick();
      irq_src   = s.src;
      irq_mask  = s.mask;
      ack_delay = int'(s.delay);
      tick();
      check_equal({name_q[i], " fast_irq"}, int'(s.exp_irq), int'(fast_irq));
      snap = pwr_ctrl;
      if (kind_q[i] == "irq") begin
        // pending unmasked interrupt with the cpu held in reset
        wake = (s.exp_irq != '0) && !cpu_exp.rst_n;
        if (wake) begin
          check_power_up(name_q[i], 0, 1'b0);
          check_done(name_q[i], 0, s, 1'b0, snap);
        end else begin
          repeat (4) begin
            tick();
            check_equal({name_q[i], " no sequence"}, 0, int'(busy));
          end
          check_equal({name_q[i], " cpu word"}, int'(s.exp_word), int'(pwr_ctrl[0]));
        end
      end else begin
        cmd_valid = 1'b1;
        cmd       = '{dom: s.dom, op: s.op};
        if (s.op == OP_ON) begin
          check_power_up(name_q[i], int'(s.dom), kind_q[i] == "drop");
        end else begin
          check_power_down(name_q[i], int'(s.dom), s.op, kind_q[i] == "drop");
        end
        check_done(name_q[i], int'(s.dom), s, s.op == OP_OFF && !s.exp_err, snap);
      end
      // expected cpu word after this line
      if (s.dom == DOM_CPU) begin
        cpu_exp = s.exp_word;
      end
    end

    $display("Verification passed");
    $finish;
  end

endmodule

/* src/ack_wait.sv */
/*
 * switch acknowledge synchronizers
 * wait for the expected level with a timeout
 */
`include "pwr_params.svh"

module ack_wait
  import pwr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [`PWR_NUM_DOMAINS-1:0] switch_ack_ni,
  input  logic                        wait_start_i,
  input  logic                        wait_level_i,
  input  domain_id_t                  wait_dom_i,
  output logic                        ack_seen_o,
  output logic                        ack_timeout_o
);

  localparam int CNT_W = $clog2(`PWR_ACK_TIMEOUT);

  logic [`PWR_NUM_DOMAINS-1:0] sync_q [`PWR_SYNC_STAGES];
  logic [`PWR_NUM_DOMAINS-1:0] ack_sync;
  logic                        active_q;
  logic                        level_q;
  domain_id_t                  dom_q;
  logic [CNT_W-1:0]            cnt_q;
  logic                        match;
  logic                        expired;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `PWR_SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= switch_ack_ni;
      for (int s = 1; s < `PWR_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign ack_sync = sync_q[`PWR_SYNC_STAGES-1];
  assign match    = (ack_sync[dom_q] == level_q);
  assign expired  = (cnt_q == CNT_W'(`PWR_ACK_TIMEOUT - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (wait_start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      if (match || expired) begin
        active_q <= 1'b0;
      end
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // expected level and domain of the running wait
  always_ff @(posedge clk_i) begin
    if (wait_start_i) begin
      level_q <= wait_level_i;
      dom_q   <= wait_dom_i;
    end
  end

  assign ack_seen_o    = active_q && match;
  assign ack_timeout_o = active_q && !match && expired;

  // a wait ends with a single report strobe
  a_single_report: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_seen_o || ack_timeout_o) |=> !(ack_seen_o || ack_timeout_o));

endmodule

/* src/irq_wakeup.sv */
/*
 * fast interrupt vector assembly and masking
 * cpu wake request while its domain is held in reset
 */
`include "pwr_params.svh"

module irq_wakeup
  import pwr_pkg::*;
(
  input  irq_src_t                         irq_src_i,
  input  fast_irq_t                        irq_mask_i,
  input  pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] pwr_ctrl_i,
  output fast_irq_t                        fast_irq_o,
  output logic                             wake_req_o
);

  fast_irq_t raw_vec;
  logic      cpu_in_reset;

  // fast interrupt lines from bit 0 upward
  // timers 2:0, dma done, spi, spi flash, gpio 13:6, dma window, external
  assign raw_vec = {
    irq_src_i.ext,
    irq_src_i.dma_window,
    irq_src_i.gpio,
    irq_src_i.spi_flash,
    irq_src_i.spi,
    irq_src_i.dma_done,
    irq_src_i.timer
  };

  // a set mask bit enables the line
  assign fast_irq_o = raw_vec & irq_mask_i;

  assign cpu_in_reset = !pwr_ctrl_i[DOM_CPU].rst_n;

  assign wake_req_o = (|fast_irq_o) && cpu_in_reset;

endmodule

/* src/mcu_power_top.sv */
/*
 * always-on power controller top
 * sequencer, domain registers, ack wait and interrupt wake-up
 */
`include "pwr_params.svh"

module mcu_power_top
  import pwr_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             cmd_valid_i,
  input  pwr_cmd_t                         cmd_i,
  input  irq_src_t                         irq_src_i,
  input  fast_irq_t                        irq_mask_i,
  input  logic [`PWR_NUM_DOMAINS-1:0]      switch_ack_ni,
  output pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] pwr_ctrl_o,
  output fast_irq_t                        fast_irq_o,
  output logic                             busy_o,
  output logic                             done_o,
  output logic                             ack_err_o
);

  logic       step_valid;
  pwr_step_e  step;
  domain_id_t step_dom;
  logic       wait_start;
  logic       wait_level;
  logic       ack_seen;
  logic       ack_timeout;
  logic       wake_req;

  pwr_seq_ctrl u_seq_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .wake_req_i    (wake_req),
    .ack_seen_i    (ack_seen),
    .ack_timeout_i (ack_timeout),
    .step_valid_o  (step_valid),
    .step_o        (step),
    .step_dom_o    (step_dom),
    .wait_start_o  (wait_start),
    .wait_level_o  (wait_level),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .ack_err_o     (ack_err_o)
  );

  pwr_domain_regs u_domain_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .step_valid_i (step_valid),
    .step_i       (step),
    .step_dom_i   (step_dom),
    .pwr_ctrl_o   (pwr_ctrl_o)
  );

  // waits on the domain the sequencer is stepping
  ack_wait u_ack_wait (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .switch_ack_ni (switch_ack_ni),
    .wait_start_i  (wait_start),
    .wait_level_i  (wait_level),
    .wait_dom_i    (step_dom),
    .ack_seen_o    (ack_seen),
    .ack_timeout_o (ack_timeout)
  );

  irq_wakeup u_irq_wakeup (
    .irq_src_i  (irq_src_i),
    .irq_mask_i (irq_mask_i),
    .pwr_ctrl_i (pwr_ctrl_o),
    .fast_irq_o (fast_irq_o),
    .wake_req_o (wake_req)
  );

endmodule

/* src/pwr_domain_regs.sv */
/*
 * control word register of every power domain
 * one line of the addressed domain changes per step strobe
 */
`include "pwr_params.svh"

module pwr_domain_regs
  import pwr_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  step_valid_i,
  input  pwr_step_e                             step_i,
  input  domain_id_t                            step_dom_i,
  output pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0]      pwr_ctrl_o
);

  pwr_ctrl_t [`PWR_NUM_DOMAINS-1:0] ctrl_q;
  logic                             is_bank;

  // only memory banks have retention cells
  assign is_bank = (step_dom_i >= DOM_BANK0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '1;
    end else if (step_valid_i) begin
      case (step_i)
        STEP_GATE_CLK:    ctrl_q[step_dom_i].clkgate_en_n <= 1'b0;
        STEP_ISOLATE:     ctrl_q[step_dom_i].isogate_en_n <= 1'b0;
        STEP_HOLD_RST:    ctrl_q[step_dom_i].rst_n        <= 1'b0;
        STEP_SWITCH_OFF:  ctrl_q[step_dom_i].pwrgate_en_n <= 1'b0;
        STEP_RETAIN: begin
          if (is_bank) begin
            ctrl_q[step_dom_i].retentive_en_n <= 1'b0;
          end
        end
        STEP_SWITCH_ON: begin
          ctrl_q[step_dom_i].retentive_en_n <= 1'b1;
          ctrl_q[step_dom_i].pwrgate_en_n   <= 1'b1;
        end
        STEP_RELEASE_ISO: ctrl_q[step_dom_i].isogate_en_n <= 1'b1;
        STEP_RELEASE_RST: ctrl_q[step_dom_i].rst_n        <= 1'b1;
        STEP_UNGATE_CLK:  ctrl_q[step_dom_i].clkgate_en_n <= 1'b1;
        default: ;
      endcase
    end
  end

  assign pwr_ctrl_o = ctrl_q;

  // an un-isolated domain must be powered across the whole step order
  for (genvar d = 0; d < `PWR_NUM_DOMAINS; d++) begin : g_chk
    a_iso_needs_power: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_q[d].isogate_en_n |-> ctrl_q[d].pwrgate_en_n);
  end

endmodule

/* src/pwr_params.svh */
/*
 * sizing of the always-on power controller
 * domain counts, acknowledge timeout, synchronizer depth, irq width
 */
`ifndef PWR_PARAMS_SVH
`define PWR_PARAMS_SVH

// memory banks, each its own power domain
`define PWR_NUM_BANKS 4

// cpu + peripheral + banks
`define PWR_NUM_DOMAINS (`PWR_NUM_BANKS + 2)

// cycles allowed for a switch acknowledge
`define PWR_ACK_TIMEOUT 64

// flops on each acknowledge line
`define PWR_SYNC_STAGES 2

// fast interrupt vector width
`define PWR_FAST_IRQ_W 16

`endif

/* src/pwr_pkg.sv */
/*
 * types shared by the power controller blocks
 * domain ids, commands, per-domain control word, steps, interrupts
 */
`include "pwr_params.svh"

package pwr_pkg;

  // 0 cpu, 1 peripheral, 2.. memory banks
  typedef logic [2:0] domain_id_t;

  localparam domain_id_t DOM_CPU   = 3'd0;
  localparam domain_id_t DOM_BANK0 = 3'd2;

  typedef enum logic [1:0] {
    OP_OFF    = 2'd0,
    OP_RETAIN = 2'd1,
    OP_ON     = 2'd2
  } pwr_op_e;

  typedef struct packed {
    domain_id_t dom;
    pwr_op_e    op;
  } pwr_cmd_t;

  // all lines active low so all ones means fully powered and running
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_t;

  typedef enum logic [3:0] {
    STEP_GATE_CLK,
    STEP_ISOLATE,
    STEP_HOLD_RST,
    STEP_SWITCH_OFF,
    STEP_RETAIN,
    STEP_SWITCH_ON,
    STEP_RELEASE_ISO,
    STEP_RELEASE_RST,
    STEP_UNGATE_CLK
  } pwr_step_e;

  typedef logic [`PWR_FAST_IRQ_W-1:0] fast_irq_t;

  // raw sources with timer[0] as timer line 1
  typedef struct packed {
    logic [2:0] timer;
    logic       spi_flash;
    logic       spi;
    logic       dma_done;
    logic [7:0] gpio;
    logic       dma_window;
    logic       ext;
  } irq_src_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PRE,
    SEQ_WAIT,
    SEQ_POST
  } seq_state_e;

endpackage

/* src/pwr_seq_ctrl.sv */
/*
 * power sequencing FSM
 * takes commands or cpu wake requests and walks the step order
 */
`include "pwr_params.svh"

module pwr_seq_ctrl
  import pwr_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cmd_valid_i,
  input  pwr_cmd_t   cmd_i,
  input  logic       wake_req_i,
  input  logic       ack_seen_i,
  input  logic       ack_timeout_i,
  output logic       step_valid_o,
  output pwr_step_e  step_o,
  output domain_id_t step_dom_o,
  output logic       wait_start_o,
  output logic       wait_level_o,
  output logic       busy_o,
  output logic       done_o,
  output logic       ack_err_o
);

  seq_state_e state_q, state_d;
  pwr_op_e    op_q;
  domain_id_t dom_q;
  logic [1:0] idx_q;
  logic       done_q;
  logic       err_q;
  logic       cmd_ok;
  logic       last_pre;
  logic       last_post;
  logic       finish;
  logic       finish_err;

  // steps before the acknowledge wait
  function automatic pwr_step_e pre_step(input pwr_op_e op, input logic [1:0] idx);
    pwr_step_e s;
    if (op == OP_ON) begin
      s = STEP_SWITCH_ON;
    end else begin
      case (idx)
        2'd0:    s = STEP_GATE_CLK;
        2'd1:    s = STEP_ISOLATE;
        2'd2:    s = STEP_HOLD_RST;
        default: s = (op == OP_RETAIN) ? STEP_RETAIN : STEP_SWITCH_OFF;
      endcase
    end
    return s;
  endfunction

  // power-on tail once the switch reports on
  function automatic pwr_step_e post_step(input logic [1:0] idx);
    pwr_step_e s;
    case (idx)
      2'd0:    s = STEP_RELEASE_ISO;
      2'd1:    s = STEP_RELEASE_RST;
      default: s = STEP_UNGATE_CLK;
    endcase
    return s;
  endfunction

  assign cmd_ok = cmd_valid_i
                  && (cmd_i.op inside {OP_OFF, OP_RETAIN, OP_ON})
                  && (int'(cmd_i.dom) < `PWR_NUM_DOMAINS);

  assign last_pre  = (op_q == OP_ON) ? (idx_q == 2'd0) : (idx_q == 2'd3);
  assign last_post = (idx_q == 2'd2);

  always_comb begin
    state_d      = state_q;
    step_valid_o = 1'b0;
    step_o       = STEP_GATE_CLK;
    wait_start_o = 1'b0;
    finish       = 1'b0;
    finish_err   = 1'b0;
    case (state_q)
      SEQ_IDLE: begin
        if (wake_req_i || cmd_ok) begin
          state_d = SEQ_PRE;
        end
      end
      SEQ_PRE: begin
        step_valid_o = 1'b1;
        step_o       = pre_step(op_q, idx_q);
        if (last_pre) begin
          if (op_q == OP_RETAIN) begin
            finish = 1'b1;
          end else begin
            wait_start_o = 1'b1;
            state_d      = SEQ_WAIT;
          end
        end
      end
      SEQ_WAIT: begin
        if (ack_seen_i) begin
          if (op_q == OP_ON) begin
            state_d = SEQ_POST;
          end else begin
            finish = 1'b1;
          end
        end else if (ack_timeout_i) begin
          finish     = 1'b1;
          finish_err = 1'b1;
        end
      end
      SEQ_POST: begin
        step_valid_o = 1'b1;
        step_o       = post_step(idx_q);
        finish       = last_post;
      end
      default: state_d = SEQ_IDLE;
    endcase
    if (finish) begin
      state_d = SEQ_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;
      err_q   <= finish_err;
      if (state_d != state_q) begin
        idx_q <= '0;
      end else if (step_valid_o) begin
        idx_q <= idx_q + 2'd1;
      end
    end
  end

  // wake request beats a command in the same cycle
  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE) begin
      if (wake_req_i) begin
        op_q  <= OP_ON;
        dom_q <= DOM_CPU;
      end else if (cmd_ok) begin
        op_q  <= cmd_i.op;
        dom_q <= cmd_i.dom;
      end
    end
  end

  assign step_dom_o   = dom_q;
  // high ack_n means the switch is open
  assign wait_level_o = (op_q == OP_OFF);
  assign busy_o       = (state_q != SEQ_IDLE);
  assign done_o       = done_q;
  assign ack_err_o    = err_q;

  // idle with no request stays quiet on the next cycle
  a_no_step_in_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == SEQ_IDLE && !wake_req_i && !cmd_ok) |=> !step_valid_o);

  a_done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule
